/* conv_layer_top.f */
conv_pkg.sv
weight_rom.sv
tap_sequencer.sv
mac_lane.sv
requant_relu.sv
conv_layer_top.sv
tb_conv_layer_top.sv

/* conv_layer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top
	import conv_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              pix_valid,
	input  wire logic [DATA_W-1:0] pix_data,
	output logic                   pix_ready,
	output logic                   ofm_valid,
	output ofm_vec_t               ofm_data,
	input  wire logic              ofm_ready,
	output logic                   layer_done
);

	tap_addr_t    rom_addr;
	pix_beat_t    tap_beat;
	logic         tap_beat_valid;
	weight_word_t weight_word;
	acc_vec_t     acc;
	logic [LANES-1:0] lane_valid;
	logic         stall;
	logic         out_accepted;

	//////////////////////////////
	// Tap sequencing and weights
	//////////////////////////////

	tap_sequencer i_tap_sequencer (
		.clk            (clk),
		.reset          (reset),
		.pix_valid      (pix_valid),
		.pix_data       (pix_data),
		.pix_ready      (pix_ready),
		.stall          (stall),
		.out_accepted   (out_accepted),
		.rom_addr       (rom_addr),
		.tap_beat       (tap_beat),
		.tap_beat_valid (tap_beat_valid),
		.layer_done     (layer_done)
	);

	weight_rom i_weight_rom (
		.clk         (clk),
		.stall       (stall),
		.rom_addr    (rom_addr),
		.weight_word (weight_word)
	);

	//////////////////////////////
	// MAC lanes
	//////////////////////////////

	// Each lane gets its own weight slice, results gathered into acc
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		mac_lane i_mac_lane (
			.clk            (clk),
			.reset          (reset),
			.stall          (stall),
			.tap_beat       (tap_beat),
			.tap_beat_valid (tap_beat_valid),
			.weight         (weight_word.lane[i]),
			.acc            (acc.lane[i]),
			.acc_valid      (lane_valid[i])
		);
	end

	// Lanes run in lockstep, lane 0 speaks for all
	requant_relu i_requant_relu (
		.clk          (clk),
		.reset        (reset),
		.acc          (acc),
		.acc_valid    (lane_valid[0]),
		.ofm_valid    (ofm_valid),
		.ofm_data     (ofm_data),
		.ofm_ready    (ofm_ready),
		.stall        (stall),
		.out_accepted (out_accepted)
	);

endmodule

`default_nettype wire

/* conv_pkg.sv */
`default_nettype none

package conv_pkg;

	//////////////////////////////
	// Layer geometry
	//////////////////////////////

	// Pixel, weight and output word
	localparam int DATA_W     = 16;
	// Accumulator word
	localparam int ACC_W      = 32;
	// Parallel output channels
	localparam int LANES      = 4;
	localparam int KERNEL_DIM = 3;
	localparam int CHIN       = 2;
	// One output pixel needs a full 3x3 window over every input channel
	localparam int TAPS       = KERNEL_DIM * KERNEL_DIM * CHIN;
	// Output vectors per layer run
	localparam int OUT_PIXELS = 4;
	// Low bit of the rescale slice
	localparam int FRAC_SHIFT = 14;

	// Per-lane bias, same scale as the accumulator
	localparam logic signed [ACC_W-1:0] BIAS [LANES] = '{
		32'sd16384,
		-32'sd8192,
		32'sd0,
		32'sd4096
	};

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [$clog2(TAPS)-1:0] tap_addr_t;

	// One tap of the input stream
	typedef struct packed {
		logic [DATA_W-1:0] pixel;
		logic              first;
		logic              last;
	} pix_beat_t;

	// Lane 0 sits in the low bits of a ROM word
	typedef struct packed {
		logic [LANES-1:0][DATA_W-1:0] lane;
	} weight_word_t;

	typedef struct packed {
		logic [LANES-1:0][ACC_W-1:0] lane;
	} acc_vec_t;

	typedef struct packed {
		logic [LANES-1:0][DATA_W-1:0] lane;
	} ofm_vec_t;

	typedef enum logic {
		RUN,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

/* layer_input.dat */
# P <pixel> : one input tap in stream order, 16-bit hex
# E <lane0> <lane1> <lane2> <lane3> : expected output vector after the taps above it
# run 1 pixel 0 : ramp 1 to 18
P 0001
P 0002
P 0003
P 0004
P 0005
P 0006
P 0007
P 0008
P 0009
P 000A
P 000B
P 000C
P 000D
P 000E
P 000F
P 0010
P 0011
P 0012
E 00AC 0055 0000 0000
# run 1 pixel 1 : 256 and 100 alternating
P 0100
P 0064
P 0100
P 0064
P 0100
P 0064
P 0100
P 0064
P 0100
P 0064
P 0100
P 0064
P 0100
P 0064
P 0100
P 0064
P 0100
P 0064
E 0C85 0641 0000 057C
# run 1 pixel 2 : -3 and -5 alternating
P FFFD
P FFFB
P FFFD
P FFFB
P FFFD
P FFFB
P FFFD
P FFFB
P FFFD
P FFFB
P FFFD
P FFFB
P FFFD
P FFFB
P FFFD
P FFFB
P FFFD
P FFFB
E 0000 0000 0048 0012
# run 1 pixel 3 : 2000 and 1990 alternating, lane 0 wraps in the slice
P 07D0
P 07C6
P 07D0
P 07C6
P 07D0
P 07C6
P 07D0
P 07C6
P 07D0
P 07C6
P 07D0
P 07C6
P 07D0
P 07C6
P 07D0
P 07C6
P 07D0
P 07C6
E 0C47 4622 0000 005A
# run 2 pixel 0 : 1024 and -256 alternating
P 0400
P FF00
P 0400
P FF00
P 0400
P FF00
P 0400
P FF00
P 0400
P FF00
P 0400
P FF00
P 0400
P FF00
P 0400
P FF00
P 0400
P FF00
E 1B01 0D7F 0000 2D00
# run 2 pixel 1 : ramp -1 to -18
P FFFF
P FFFE
P FFFD
P FFFC
P FFFB
P FFFA
P FFF9
P FFF8
P FFF7
P FFF6
P FFF5
P FFF4
P FFF3
P FFF2
P FFF1
P FFF0
P FFEF
P FFEE
E 0000 0000 00AB 0009
# run 2 pixel 2 : all zero so only the bias remains
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
P 0000
E 0001 0000 0000 0000
# run 2 pixel 3 : -2000 and -2010 alternating, lane 2 wraps in the slice
P F830
P F826
P F830
P F826
P F830
P F826
P F830
P F826
P F830
P F826
P F830
P F826
P F830
P F826
P F830
P F826
P F830
P F826
E 0000 0000 0CFA 005A

/* mac_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_lane
	import conv_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              stall,
	input  wire pix_beat_t         tap_beat,
	input  wire logic              tap_beat_valid,
	input  wire logic [DATA_W-1:0] weight,
	output logic [ACC_W-1:0]       acc,
	output logic                   acc_valid
);

	logic signed [2*DATA_W-1:0] prod;
	logic signed [ACC_W-1:0]    prod_ext;

	// Signed Q-format product
	assign prod     = $signed(tap_beat.pixel) * $signed(weight);
	// Sign extend up to accumulator width
	assign prod_ext = prod;

	// First tap restarts the sum, no separate clear cycle
	always_ff @(posedge clk) begin
		if (!stall && tap_beat_valid) begin
			if (tap_beat.first)
				acc <= prod_ext;
			else
				acc <= acc + prod_ext;
		end
	end

	// Sum complete after the last tap
	always_ff @(posedge clk) begin
		if (reset)
			acc_valid <= 1'b0;
		else if (!stall)
			acc_valid <= tap_beat_valid && tap_beat.last;
	end

endmodule

`default_nettype wire

/* requant_relu.sv */
`timescale 1ns/1ps
`default_nettype none

module requant_relu
	import conv_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire acc_vec_t acc,
	input  wire logic acc_valid,
	output logic      ofm_valid,
	output ofm_vec_t  ofm_data,
	input  wire logic ofm_ready,
	output logic      stall,
	output logic      out_accepted
);

	logic signed [ACC_W-1:0] biased [LANES];
	ofm_vec_t                next_ofm;
	logic                    load;

	//////////////////////////////
	// Bias, ReLU, rescale
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			biased[i] = $signed(acc.lane[i]) + BIAS[i];
			// Negative sums clamp to zero
			if (biased[i][ACC_W-1])
				next_ofm.lane[i] = '0;
			// Plain truncation, top bits above the slice dropped
			else
				next_ofm.lane[i] = {1'b0, biased[i][FRAC_SHIFT+DATA_W-2:FRAC_SHIFT]};
		end
	end

	//////////////////////////////
	// Output handshake
	//////////////////////////////

	// Blocked output freezes everything upstream
	assign stall        = ofm_valid && !ofm_ready;
	assign out_accepted = ofm_valid && ofm_ready;
	// Register is free or being emptied this cycle
	assign load         = acc_valid && !stall;

	always_ff @(posedge clk) begin
		if (reset)
			ofm_valid <= 1'b0;
		else if (load)
			ofm_valid <= 1'b1;
		else if (out_accepted)
			ofm_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load)
			ofm_data <= next_ofm;
	end

endmodule

`default_nettype wire

/* tap_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module tap_sequencer
	import conv_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              pix_valid,
	input  wire logic [DATA_W-1:0] pix_data,
	output logic                   pix_ready,
	input  wire logic              stall,
	input  wire logic              out_accepted,
	output tap_addr_t              rom_addr,
	output pix_beat_t              tap_beat,
	output logic                   tap_beat_valid,
	output logic                   layer_done
);

	seq_state_t state;
	tap_addr_t  tap_cnt;
	logic [$clog2(OUT_PIXELS+1)-1:0] pix_cnt;
	logic [$clog2(OUT_PIXELS+1)-1:0] out_cnt;
	// Stage 0 holds the tap while the ROM reads its weights
	pix_beat_t  beat0;
	logic       beat0_valid;
	logic       accept;
	logic       tap_last;

	// No new taps once the layer is issued or the output is blocked
	assign pix_ready = (state == RUN) && !stall;
	assign accept    = pix_valid && pix_ready;
	assign tap_last  = (tap_cnt == tap_addr_t'(TAPS - 1));

	//////////////////////////////
	// Tap counter and ROM address
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			tap_cnt     <= '0;
			rom_addr    <= '0;
			beat0_valid <= 1'b0;
		end else if (!stall) begin
			beat0_valid <= accept;
			if (accept) begin
				// Address goes out with the tap, read lands next edge
				rom_addr <= tap_cnt;
				if (tap_last)
					tap_cnt <= '0;
				else
					tap_cnt <= tap_cnt + 1'b1;
			end
		end
	end

	// Tap payload, flags mark window boundaries
	always_ff @(posedge clk) begin
		if (!stall && accept) begin
			beat0.pixel <= pix_data;
			beat0.first <= (tap_cnt == '0);
			beat0.last  <= tap_last;
		end
	end

	// Second stage lines up with the registered ROM word
	always_ff @(posedge clk) begin
		if (reset)
			tap_beat_valid <= 1'b0;
		else if (!stall)
			tap_beat_valid <= beat0_valid;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			tap_beat <= beat0;
	end

	//////////////////////////////
	// Layer progress
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= RUN;
			pix_cnt <= '0;
		end else if (accept && tap_last) begin
			pix_cnt <= pix_cnt + 1'b1;
			// Final window issued, close the input
			if (pix_cnt == OUT_PIXELS - 1)
				state <= DONE;
		end
	end

	// Done only once the last vector has left the output
	always_ff @(posedge clk) begin
		if (reset) begin
			out_cnt    <= '0;
			layer_done <= 1'b0;
		end else if (out_accepted && !layer_done) begin
			out_cnt <= out_cnt + 1'b1;
			if (out_cnt == OUT_PIXELS - 1)
				layer_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* tb_conv_layer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_layer_top
	import conv_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 16;
	localparam int RUN_TAPS     = OUT_PIXELS * TAPS;
	// Idle cycles before a tap when gaps are on
	localparam int MAX_GAP      = 3;
	localparam int END_CYCLES   = 8;
	// Last tap accepted to ofm_valid high
	localparam int PIPE_LATENCY = 3;
	// Twice both runs at worst gap plus resets and end windows
	localparam int WATCHDOG_CYCLES = 2 * (2 * RUN_TAPS) * (MAX_GAP + 1)
		+ 3 * RESET_CYCLES + 4 * END_CYCLES;
	localparam logic [31:0] LFSR_SEED = 32'he0be336c;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	// Test ids
	localparam int T_RESET        = 0;
	localparam int T_STREAM       = 1;
	localparam int T_LATENCY      = 2;
	localparam int T_GAPS         = 3;
	localparam int T_BACKPRESSURE = 4;
	localparam int T_END          = 5;
	localparam int NUM_TESTS      = 6;

	logic              clk;
	logic              reset;
	logic              pix_valid;
	logic [DATA_W-1:0] pix_data;
	logic              pix_ready;
	logic              ofm_valid;
	ofm_vec_t          ofm_data;
	logic              ofm_ready;
	logic              layer_done;

	logic [31:0]       lfsr_state = LFSR_SEED;
	logic [DATA_W-1:0] pix_all [$];
	ofm_vec_t          exp_all [$];
	// Expected vectors still owed by the current run
	ofm_vec_t          exp_q [$];
	// Acceptance cycles of last taps for the latency check
	int                last_q [$];
	int                errs [NUM_TESTS];
	int                setup_errs = 0;
	int                pass_tests = 0;
	int                fail_tests = 0;
	int                cyc = 0;
	int                got_count = 0;
	int                vec_test = T_STREAM;
	bit                check_latency = 1'b0;
	bit                ready_random = 1'b0;
	bit                next_ready;
	bit                holding = 1'b0;
	ofm_vec_t          held_vec;

	conv_layer_top i_conv_layer_top (
		.clk        (clk),
		.reset      (reset),
		.pix_valid  (pix_valid),
		.pix_data   (pix_data),
		.pix_ready  (pix_ready),
		.ofm_valid  (ofm_valid),
		.ofm_data   (ofm_data),
		.ofm_ready  (ofm_ready),
		.layer_done (layer_done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Rising edge count sampled at the falling edge
	always @(posedge clk) cyc <= cyc + 1;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	// One LFSR step per bit
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	function automatic string test_name(input int id);
		case (id)
			T_RESET:        return "reset_state";
			T_STREAM:       return "stream_values";
			T_LATENCY:      return "fixed_latency";
			T_GAPS:         return "gap_values";
			T_BACKPRESSURE: return "backpressure";
			default:        return "layer_end";
		endcase
	endfunction

	task automatic expect_vec(input int id, input ofm_vec_t exp_vec, input ofm_vec_t act_vec);
		assert (act_vec === exp_vec) else begin
			$display("ERR %s expected %h actual %h", test_name(id), exp_vec, act_vec);
			errs[id]++;
		end
	endtask

	task automatic expect_int(input int id, input string what, input integer exp_val,
		input integer act_val);
		assert (act_val === exp_val) else begin
			$display("ERR %s %s expected %0d actual %0d", test_name(id), what, exp_val,
				act_val);
			errs[id]++;
		end
	endtask

	task automatic expect_true(input int id, input bit cond, input string what);
		assert (cond) else begin
			$display("%s failed: %s", test_name(id), what);
			errs[id]++;
		end
	endtask

	//////////////////////////////
	// Data file
	//////////////////////////////

	task automatic load_data;
		int                fd;
		int                n;
		string             line;
		logic [DATA_W-1:0] v [LANES];
		ofm_vec_t          vec;
		fd = $fopen("layer_input.dat", "r");
		if (fd == 0) begin
			$display("could not open layer_input.dat");
			setup_errs++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line[0] == "P") begin
				n = $sscanf(line, "P %h", v[0]);
				if (n != 1) begin
					$display("pixel line %0d of layer_input.dat could not be parsed",
						pix_all.size());
					setup_errs++;
				end
				pix_all.push_back(v[0]);
			end else if (line.len() > 0 && line[0] == "E") begin
				n = $sscanf(line, "E %h %h %h %h", v[0], v[1], v[2], v[3]);
				if (n != LANES) begin
					$display("expected line %0d of layer_input.dat could not be parsed",
						exp_all.size());
					setup_errs++;
				end
				// Lane order in the file is 0 to 3
				for (int i = 0; i < LANES; i++)
					vec.lane[i] = v[i];
				exp_all.push_back(vec);
			end
		end
		$fclose(fd);
		if (pix_all.size() != 2 * RUN_TAPS || exp_all.size() != 2 * OUT_PIXELS) begin
			$display("layer_input.dat does not hold two complete layer runs");
			setup_errs++;
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic apply_reset;
		reset     = 1'b1;
		pix_valid = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
	endtask

	task automatic check_reset_state(input int id);
		@(negedge clk);
		expect_int(id, "pix_ready", 1, pix_ready);
		expect_int(id, "ofm_valid", 0, ofm_valid);
		expect_int(id, "layer_done", 0, layer_done);
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Entered and left just after a rising edge
	task automatic send_tap(input logic [DATA_W-1:0] value, input bit is_last,
		input bit use_gaps);
		int gap;
		bit taken;
		gap = use_gaps ? take_bits(2) : 0;
		if (gap > 0) begin
			pix_valid = 1'b0;
			repeat (gap) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
		end
		pix_valid = 1'b1;
		pix_data  = value;
		taken     = 1'b0;
		while (!taken) begin
			// Ready seen here holds through the next edge
			@(negedge clk);
			if (pix_ready) begin
				taken = 1'b1;
				if (is_last && check_latency)
					last_q.push_back(cyc + 1);
			end
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic send_run(input int run, input bit use_gaps);
		exp_q.delete();
		last_q.delete();
		for (int i = 0; i < OUT_PIXELS; i++)
			exp_q.push_back(exp_all[run * OUT_PIXELS + i]);
		got_count = 0;
		for (int i = 0; i < RUN_TAPS; i++)
			send_tap(pix_all[run * RUN_TAPS + i], (i % TAPS) == TAPS - 1, use_gaps);
		pix_valid = 1'b0;
	endtask

	// Input offered after the layer must not move anything
	task automatic check_layer_end;
		vec_test = T_END;
		@(posedge clk);
		#DRIVE_DELAY;
		pix_valid = 1'b1;
		pix_data  = 16'h7fff;
		repeat (END_CYCLES) begin
			@(negedge clk);
			expect_int(T_END, "layer_done", 1, layer_done);
			expect_int(T_END, "pix_ready", 0, pix_ready);
			expect_int(T_END, "ofm_valid", 0, ofm_valid);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		pix_valid = 1'b0;
	endtask

	task automatic report_test(input int id);
		if (errs[id] == 0) begin
			pass_tests++;
			$display("%s: ok", test_name(id));
		end else begin
			fail_tests++;
			$display("%s: failed with %0d errors", test_name(id), errs[id]);
		end
	endtask

	//////////////////////////////
	// Output side
	//////////////////////////////

	task automatic measure_latency;
		if (last_q.size() == 0)
			expect_true(T_LATENCY, 1'b0, "output vector without a matching last tap");
		else
			expect_int(T_LATENCY, "latency", PIPE_LATENCY, cyc - last_q.pop_front());
	endtask

	task automatic take_vector;
		if (exp_q.size() == 0)
			expect_true(vec_test, 1'b0, "output vector appeared after the layer finished");
		else
			expect_vec(vec_test, exp_q.pop_front(), ofm_data);
		got_count++;
	endtask

	// Ready drawn at the falling edge and driven after the rising edge
	always begin : ready_driver
		@(negedge clk);
		next_ready = ready_random ? take_bits(1) : 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		ofm_ready = next_ready;
	end

	always @(negedge clk) begin : monitor
		if (reset) begin
			holding = 1'b0;
		end else if (ofm_valid) begin
			// Waiting vector must not move
			if (holding)
				expect_vec(T_BACKPRESSURE, held_vec, ofm_data);
			else if (check_latency)
				measure_latency();
			if (ofm_ready) begin
				take_vector();
				holding = 1'b0;
			end else begin
				if (!holding)
					held_vec = ofm_data;
				holding = 1'b1;
			end
		end
	end

	//////////////////////////////
	// Sequence
	//////////////////////////////

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired, the DUT stopped making progress");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : main
		clk       = 1'b0;
		reset     = 1'b1;
		pix_valid = 1'b0;
		pix_data  = '0;
		ofm_ready = 1'b1;
		foreach (errs[i])
			errs[i] = 0;
		load_data();
		if (setup_errs == 0) begin
			apply_reset();
			check_reset_state(T_RESET);
			report_test(T_RESET);
			// Run 1 streams back to back with the output always ready
			vec_test      = T_STREAM;
			check_latency = 1'b1;
			send_run(0, 1'b0);
			wait (got_count == OUT_PIXELS);
			check_latency = 1'b0;
			check_layer_end();
			report_test(T_STREAM);
			report_test(T_LATENCY);
			apply_reset();
			check_reset_state(T_END);
			// Run 2 with input gaps and output stalls
			vec_test     = T_GAPS;
			ready_random = 1'b1;
			send_run(1, 1'b1);
			wait (got_count == OUT_PIXELS);
			ready_random = 1'b0;
			check_layer_end();
			report_test(T_GAPS);
			report_test(T_BACKPRESSURE);
			apply_reset();
			check_reset_state(T_END);
			report_test(T_END);
		end
		$display("tests passed %0d failed %0d", pass_tests, fail_tests);
		if (fail_tests == 0 && setup_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* weight_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_rom
	import conv_pkg::*;
(
	input  wire logic clk,
	input  wire logic stall,
	input  wire tap_addr_t rom_addr,
	output weight_word_t weight_word
);

	// One word per tap, all lanes side by side
	weight_word_t mem [TAPS];

	initial begin
		$readmemh("weights.mem", mem);
	end

	// Registered read, frozen with the rest of the pipe
	always_ff @(posedge clk) begin
		if (!stall)
			weight_word <= mem[rom_addr];
	end

endmodule

`default_nettype wire

/* weights.mem */
// One word per tap, lanes 3 2 1 0 from the left
// Lane 3 alternates sign between even and odd taps
4000C00020004000
C000C00020004000
4000C00020004000
C000C00020004000
4000C00020004000
C000C00020004000
4000C00020004000
C000C00020004000
4000C00020004000
C000C00020004000
4000C00020004000
C000C00020004000
4000C00020004000
C000C00020004000
4000C00020004000
C000C00020004000
4000C00020004000
C000C00020004000
